// File: build.f
+incdir+hdl
hdl/srl_cmd_pkg.sv
hdl/srl_result_pkg.sv
hdl/srl_pattern_source.sv
hdl/srl_lane.sv
hdl/srl_error_collector.sv
hdl/srl_test_array.sv
tests/srl_test_array_chk.sv
tests/srl_test_array_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SRL lane tester simulation with Verilator
set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module srl_test_array_tb -f build.f -o srl_test_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/srl_test_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// File: tests/srl_test_cases.txt
// Columns: pattern words 0 to 7, fault enable, fault lane, fault stage,
// first delay, last delay, expected count of lanes 0 to 7 (all hex)
// Fault off, every lane clean
0123abcd f00dcafe 5a5a33cc 0f0f1e2d 89abcdef 13579bdf 2468ace0 deadbeef 0 0 00 00 03 0 0 0 0 0 0 0 0
// Lane 3 stage 4 over delays 1 to 6, three delays hit
a5a5a5a5 3c3c0ff0 77881122 9e3779b9 c001d00d 0badf00d 55aa55aa 12345678 1 3 04 01 06 0 0 0 2a0 0 0 0 0
// Stage above the whole delay range
6b8b4567 327b23c6 643c9869 66334873 74b0dc51 19495cff 2ae8944a 625558ec 1 5 14 02 08 0 0 0 0 0 0 0 0
// New pattern and lane, stage 0 inverts every tap
ffff0000 0000ffff aaaa5555 5555aaaa 01010101 80808080 fedcba98 76543210 1 6 00 00 01 0 0 0 0 0 0 1c0 0
// Lane 0 stage 10, delays 10 to 13 hit
238e1f29 46e87ccd 3d1b58ba 507ed7ab 2eb141f2 41b71efb 79e2a9e3 7545e146 1 0 0a 09 0d 380 0 0 0 0 0 0 0
// Top stage on the last lane
515f007c 5bd062c2 12200854 4db127f8 0216231b 1f16e9e8 1190cde7 66ef438d 1 7 1f 1d 1f 0 0 0 0 0 0 0 e0

// File: tests/srl_test_array_tb.sv
`include "srl_test_params.svh"

module srl_test_array_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES        = 6;
    localparam int F_FAULT_EN       = 8;
    localparam int F_FAULT_LANE     = 9;
    localparam int F_FAULT_STAGE    = 10;
    localparam int F_FIRST          = 11;
    localparam int F_LAST           = 12;
    localparam int F_COUNT          = 13;
    localparam int FIELDS           = F_COUNT + `SRL_NUM_LANES;
    localparam int CYCLES_PER_DELAY = 3 * `SRL_PATTERN_BITS;
    localparam int CASE_MARGIN      = 1000;
    // Compares per delay once the inhibit window is over
    localparam int CHECKED_SAMPLES  = `SRL_PATTERN_BITS - `SRL_LENGTH;

    localparam logic [1:0] OPC_LOAD = 2'b01;
    localparam logic [1:0] OPC_RUN  = 2'b10;

    logic                       clk;
    logic                       rst;
    logic                       cmd_valid;
    logic                       cmd_ready;
    logic [`SRL_CMD_BITS-1:0]   cmd_word;
    logic                       res_valid;
    logic                       res_ready;
    logic [`SRL_LANE_BITS-1:0]  res_lane;
    logic [`SRL_COUNT_BITS-1:0] res_count;

    logic [31:0] case_mem [NUM_CASES * FIELDS];
    logic [15:0] lfsr;
    int          cycle_cnt;
    int          cycle_limit;
    int          check_fails;
    int          case_fails;

    srl_test_array dut0 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_word  (cmd_word),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_lane  (res_lane),
        .res_count (res_count)
    );

    bind srl_test_array srl_test_array_chk chk0 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_word  (cmd_word),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_lane  (res_lane),
        .res_count (res_count)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Run limit is set once the cases are read
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Helpers

    function automatic logic [31:0] case_field(input int c, input int f);
        return case_mem[c * FIELDS + f];
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [`SRL_CMD_BITS-1:0] load_word(
        input logic [2:0]                idx,
        input logic [`SRL_WORD_BITS-1:0] data
    );
        return {OPC_LOAD, idx, data, 3'b000};
    endfunction

    function automatic logic [`SRL_CMD_BITS-1:0] run_word(
        input logic [`SRL_TAP_BITS-1:0]  first,
        input logic [`SRL_TAP_BITS-1:0]  last,
        input logic                      fen,
        input logic [`SRL_LANE_BITS-1:0] flane,
        input logic [`SRL_TAP_BITS-1:0]  fstage
    );
        return {OPC_RUN, first, last, fen, flane, fstage, 19'd0};
    endfunction

    // Faulty stage inverts every tap at or above it
    function automatic int rule_count(input int c, input int lane);
        logic [31:0] fen;
        int          flane;
        int          fstage;
        int          first;
        int          last;
        int          total;
        int          a;
        fen    = case_field(c, F_FAULT_EN);
        flane  = int'(case_field(c, F_FAULT_LANE));
        fstage = int'(case_field(c, F_FAULT_STAGE));
        first  = int'(case_field(c, F_FIRST));
        last   = int'(case_field(c, F_LAST));
        total  = 0;
        if (fen[0] && flane == lane) begin
            for (a = first; a <= last; a++)
                if (a >= fstage)
                    total += CHECKED_SAMPLES;
        end
        return total;
    endfunction

    // Called on a rising edge and returns on the edge that takes the command
    task automatic send_cmd(input logic [`SRL_CMD_BITS-1:0] word);
        cmd_valid <= 1'b1;
        cmd_word  <= word;
        @(negedge clk);
        while (!cmd_ready)
            @(negedge clk);
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic collect_results(input int c);
        int                        got;
        logic [`SRL_LANE_BITS-1:0] want_lane;
        logic [31:0]               want_word;
        logic [15:0]               want;
        got = 0;
        while (got < `SRL_NUM_LANES) begin
            lfsr = lfsr_next(lfsr);
            res_ready <= lfsr[0];
            @(negedge clk);
            if (res_valid && res_ready) begin
                want_lane = got[`SRL_LANE_BITS-1:0];
                want_word = case_field(c, F_COUNT + got);
                want      = want_word[15:0];
                if (res_lane != want_lane) begin
                    $display("FAILED at %0t: case %0d result %0d from lane %0d, expected lane %0d",
                             $time, c, got, res_lane, want_lane);
                    check_fails++;
                end
                if (res_count != want) begin
                    $display("FAILED at %0t: case %0d lane %0d count %0d, expected %0d",
                             $time, c, want_lane, res_count, want);
                    check_fails++;
                end
                got++;
            end
            @(posedge clk);
        end
        res_ready <= 1'b0;
    endtask

    task automatic run_case(input int c);
        int          fails_before;
        int          i;
        logic [31:0] fen;
        logic [31:0] flane;
        logic [31:0] fstage;
        logic [31:0] first;
        logic [31:0] last;
        fails_before = check_fails;
        // Listed counts must agree with the fault rule
        for (i = 0; i < `SRL_NUM_LANES; i++) begin
            if (int'(case_field(c, F_COUNT + i)) != rule_count(c, i)) begin
                $display("Case file error: case %0d lane %0d lists %0d but the rule gives %0d",
                         c, i, case_field(c, F_COUNT + i), rule_count(c, i));
                check_fails++;
            end
        end
        for (i = 0; i < 8; i++)
            send_cmd(load_word(i[2:0], case_field(c, i)));
        fen    = case_field(c, F_FAULT_EN);
        flane  = case_field(c, F_FAULT_LANE);
        fstage = case_field(c, F_FAULT_STAGE);
        first  = case_field(c, F_FIRST);
        last   = case_field(c, F_LAST);
        send_cmd(run_word(first[4:0], last[4:0], fen[0], flane[2:0], fstage[4:0]));
        collect_results(c);
        if (check_fails == fails_before) begin
            $display("case %0d: delays %0d..%0d, fault lane %0d stage %0d, ok",
                     c, first, last, flane, fstage);
        end else begin
            $display("case %0d: %0d checks wrong", c, check_fails - fails_before);
            case_fails++;
        end
    endtask

    // ========================================================================
    // Main sequence

    initial begin
        int c;
        int ndelays;
        rst         = 1'b1;
        cmd_valid   = 1'b0;
        cmd_word    = '0;
        res_ready   = 1'b0;
        lfsr        = 16'd58;
        cycle_cnt   = 0;
        cycle_limit = 0;
        check_fails = 0;
        case_fails  = 0;

        $readmemh("tests/srl_test_cases.txt", case_mem);
        for (c = 0; c < NUM_CASES; c++) begin
            ndelays = int'(case_field(c, F_LAST)) - int'(case_field(c, F_FIRST)) + 1;
            cycle_limit += CYCLES_PER_DELAY * ndelays + CASE_MARGIN;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (c = 0; c < NUM_CASES; c++)
            run_case(c);

        $display("Summary: %0d cases, %0d failed, %0d wrong checks",
                 NUM_CASES, case_fails, check_fails);
        if (check_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tests/srl_test_array_chk.sv
`include "srl_test_params.svh"

module srl_test_array_chk (
    input logic                       clk,
    input logic                       rst,
    input logic                       cmd_valid,
    input logic                       cmd_ready,
    input logic [`SRL_CMD_BITS-1:0]   cmd_word,
    input logic                       res_valid,
    input logic                       res_ready,
    input logic [`SRL_LANE_BITS-1:0]  res_lane,
    input logic [`SRL_COUNT_BITS-1:0] res_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // Host holds a pending command unchanged
    a_cmd_hold: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_word)
    ) else $error("command word changed before it was accepted");

    // Offered result stays put until taken
    a_res_hold: assert property (
        @(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_lane) && $stable(res_count)
    ) else $error("result changed or was withdrawn before it was accepted");

    // Results only while a run holds off new commands
    a_res_busy: assert property (
        @(posedge clk) disable iff (rst)
        res_valid |-> !cmd_ready
    ) else $error("result offered while commands were being accepted");

endmodule

// File: hdl/srl_test_array.sv
`include "srl_test_params.svh"

module srl_test_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic [`SRL_CMD_BITS-1:0]       cmd_word,
    output logic                           res_valid,
    input  logic                           res_ready,
    output srl_result_pkg::srl_lane_idx_t  res_lane,
    output srl_result_pkg::srl_count_t     res_count
);
    import srl_result_pkg::*;

    logic                       sh;
    logic                       d;
    logic [`SRL_TAP_BITS-1:0]   tap;
    logic                       expect_bit;
    logic                       check_en;
    logic                       fault_en;
    logic [`SRL_LANE_BITS-1:0]  fault_lane;
    logic [`SRL_TAP_BITS-1:0]   fault_stage;
    logic                       run_done;
    logic                       drained;
    logic [`SRL_NUM_LANES-1:0]  err;

    srl_pattern_source source0 (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_word    (cmd_word),
        .drained     (drained),
        .sh          (sh),
        .d           (d),
        .tap         (tap),
        .expect_bit  (expect_bit),
        .check_en    (check_en),
        .fault_en    (fault_en),
        .fault_lane  (fault_lane),
        .fault_stage (fault_stage),
        .run_done    (run_done)
    );

    // All lanes see the same broadcast
    for (genvar i = 0; i < `SRL_NUM_LANES; i++) begin : g_lane
        srl_lane lane0 (
            .clk         (clk),
            .rst         (rst),
            .lane_idx    (srl_lane_idx_t'(i)),
            .sh          (sh),
            .d           (d),
            .tap         (tap),
            .expect_bit  (expect_bit),
            .check_en    (check_en),
            .fault_en    (fault_en),
            .fault_lane  (fault_lane),
            .fault_stage (fault_stage),
            .err         (err[i])
        );
    end

    srl_error_collector collector0 (
        .clk       (clk),
        .rst       (rst),
        .err       (err),
        .run_done  (run_done),
        .drained   (drained),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_lane  (res_lane),
        .res_count (res_count)
    );

endmodule

// File: hdl/srl_error_collector.sv
`include "srl_test_params.svh"

module srl_error_collector (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`SRL_NUM_LANES-1:0]      err,
    input  logic                           run_done,
    output logic                           drained,
    output logic                           res_valid,
    input  logic                           res_ready,
    output srl_result_pkg::srl_lane_idx_t  res_lane,
    output srl_result_pkg::srl_count_t     res_count
);
    import srl_result_pkg::*;

    localparam srl_lane_idx_t LAST_LANE = srl_lane_idx_t'(`SRL_NUM_LANES - 1);

    srl_count_t    cnt [`SRL_NUM_LANES];
    srl_lane_idx_t ptr;
    logic          taken;

    assign taken = res_valid && res_ready;

    // ========================================================================
    // Per-lane error counters

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SRL_NUM_LANES; i++)
                cnt[i] <= '0;
        end else begin
            for (int i = 0; i < `SRL_NUM_LANES; i++) begin
                // Delivered count is cleared for the next run
                if (taken && ptr == srl_lane_idx_t'(i))
                    cnt[i] <= '0;
                else if (err[i] && cnt[i] != '1)
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    // ========================================================================
    // Result drain in lane order

    // Last error of the run lands together with run_done
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            ptr       <= '0;
        end else if (run_done) begin
            res_valid <= 1'b1;
            ptr       <= '0;
        end else if (taken) begin
            if (ptr == LAST_LANE)
                res_valid <= 1'b0;
            else
                ptr <= ptr + 1'b1;
        end
    end

    assign res_lane  = ptr;
    assign res_count = cnt[ptr];

    // Nothing left to deliver
    assign drained = !res_valid;

endmodule

// File: hdl/srl_lane.sv
`include "srl_test_params.svh"

module srl_lane (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`SRL_LANE_BITS-1:0]  lane_idx,
    input  logic                       sh,
    input  logic                       d,
    input  logic [`SRL_TAP_BITS-1:0]   tap,
    input  logic                       expect_bit,
    input  logic                       check_en,
    input  logic                       fault_en,
    input  logic [`SRL_LANE_BITS-1:0]  fault_lane,
    input  logic [`SRL_TAP_BITS-1:0]   fault_stage,
    output logic                       err
);

    logic [`SRL_LENGTH-1:0] sr;
    logic [`SRL_LENGTH-1:0] sr_in;
    logic                   fault_hit;
    logic                   tap_q;

    // ========================================================================
    // Shift register under test

    assign fault_hit = fault_en && (fault_lane == lane_idx);

    // Stage 0 takes the new bit and stage k takes stage k-1
    always_comb begin
        sr_in = {sr[`SRL_LENGTH-2:0], d};
        // Injected fault flips what one stage stores
        if (fault_hit)
            sr_in[fault_stage] = ~sr_in[fault_stage];
    end

    always_ff @(posedge clk) begin
        if (sh)
            sr <= sr_in;
    end

    // Read port where address 0 is the newest bit
    assign tap_q = sr[tap];

    // ========================================================================
    // Compare against the expected bit

    always_ff @(posedge clk) begin
        if (rst)
            err <= 1'b0;
        else
            err <= check_en && (tap_q ^ expect_bit);
    end

endmodule

// File: hdl/srl_pattern_source.sv
`include "srl_test_params.svh"

module srl_pattern_source (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  srl_cmd_pkg::srl_cmd_u      cmd_word,
    input  logic                       drained,
    output logic                       sh,
    output logic                       d,
    output logic [`SRL_TAP_BITS-1:0]   tap,
    output logic                       expect_bit,
    output logic                       check_en,
    output logic                       fault_en,
    output logic [`SRL_LANE_BITS-1:0]  fault_lane,
    output logic [`SRL_TAP_BITS-1:0]   fault_stage,
    output logic                       run_done
);
    import srl_cmd_pkg::*;

    localparam int SAMPLE_BITS = $clog2(`SRL_PATTERN_BITS);
    localparam int INH_BITS    = $clog2(`SRL_LENGTH + 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    logic [1:0]                    state;
    logic [1:0]                    phase;
    logic [`SRL_PATTERN_BITS-1:0]  pattern;
    logic [SAMPLE_BITS-1:0]        sample_n;
    logic [SAMPLE_BITS-1:0]        exp_addr;
    logic [`SRL_TAP_BITS-1:0]      last_delay;
    logic [INH_BITS-1:0]           inh_cnt;
    logic                          cmd_acc;
    logic                          last_sample;

    // ========================================================================
    // Command intake

    assign cmd_ready = (state == ST_IDLE);
    assign cmd_acc   = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pattern <= '0;
        end else if (cmd_acc && cmd_word.load.opcode == OP_LOAD) begin
            pattern[cmd_word.load.word_idx * `SRL_WORD_BITS +: `SRL_WORD_BITS] <=
                cmd_word.load.data;
        end
    end

    // ========================================================================
    // Sample sequencer with three cycles per sample

    assign last_sample = (sample_n == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            phase       <= 2'd0;
            sample_n    <= '0;
            tap         <= '0;
            last_delay  <= '0;
            inh_cnt     <= '0;
            fault_en    <= 1'b0;
            fault_lane  <= '0;
            fault_stage <= '0;
            run_done    <= 1'b0;
        end else begin
            run_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_acc && cmd_word.run.opcode == OP_RUN) begin
                        state       <= ST_RUN;
                        phase       <= 2'd0;
                        sample_n    <= '0;
                        tap         <= cmd_word.run.first_delay;
                        last_delay  <= cmd_word.run.last_delay;
                        inh_cnt     <= INH_BITS'(`SRL_LENGTH);
                        fault_en    <= cmd_word.run.fault_en;
                        fault_lane  <= cmd_word.run.fault_lane;
                        fault_stage <= cmd_word.run.fault_stage;
                    end
                end
                ST_RUN: begin
                    phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
                    if (phase == 2'd2) begin
                        sample_n <= sample_n + 1'b1;
                        if (inh_cnt != '0)
                            inh_cnt <= inh_cnt - 1'b1;
                        // Pattern wrapped so the sweep moves to the next delay
                        if (last_sample) begin
                            inh_cnt <= INH_BITS'(`SRL_LENGTH);
                            if (tap == last_delay) begin
                                state    <= ST_WAIT;
                                run_done <= 1'b1;
                            end else begin
                                tap <= tap + 1'b1;
                            end
                        end
                    end
                end
                ST_WAIT: begin
                    // Collector only sees run_done a cycle later
                    if (drained && !run_done)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ========================================================================
    // Lane broadcast

    assign sh       = (state == ST_RUN) && (phase == 2'd0);
    assign d        = pattern[sample_n];
    assign check_en = (state == ST_RUN) && (phase == 2'd2) && (inh_cnt == '0);

    // Bit written tap samples ago with wrap around the pattern
    assign exp_addr = sample_n - SAMPLE_BITS'(tap);

    always_ff @(posedge clk) begin
        if (state == ST_RUN && phase == 2'd1)
            expect_bit <= pattern[exp_addr];
    end

endmodule

// File: hdl/srl_result_pkg.sv
`include "srl_test_params.svh"

package srl_result_pkg;

    // Which lane a result belongs to
    typedef logic [`SRL_LANE_BITS-1:0] srl_lane_idx_t;

    // Saturating mismatch count of one lane over a run
    typedef logic [`SRL_COUNT_BITS-1:0] srl_count_t;

endpackage

// File: hdl/srl_cmd_pkg.sv
`include "srl_test_params.svh"

package srl_cmd_pkg;

    localparam int WORD_IDX_BITS = $clog2(`SRL_PATTERN_BITS / `SRL_WORD_BITS);

    // Padding so both views fill the whole command word
    localparam int LOAD_PAD_BITS = `SRL_CMD_BITS - 2 - WORD_IDX_BITS - `SRL_WORD_BITS;
    localparam int RUN_PAD_BITS  = `SRL_CMD_BITS - 2 - 3 * `SRL_TAP_BITS - 1 - `SRL_LANE_BITS;

    typedef enum logic [1:0] {
        OP_NONE = 2'b00,
        OP_LOAD = 2'b01,
        OP_RUN  = 2'b10
    } srl_opcode_e;

    // Pattern word write
    typedef struct packed {
        srl_opcode_e                opcode;
        logic [WORD_IDX_BITS-1:0]   word_idx;
        logic [`SRL_WORD_BITS-1:0]  data;
        logic [LOAD_PAD_BITS-1:0]   pad;
    } srl_load_view_t;

    // Run start with delay sweep and fault setting
    typedef struct packed {
        srl_opcode_e                opcode;
        logic [`SRL_TAP_BITS-1:0]   first_delay;
        logic [`SRL_TAP_BITS-1:0]   last_delay;
        logic                       fault_en;
        logic [`SRL_LANE_BITS-1:0]  fault_lane;
        logic [`SRL_TAP_BITS-1:0]   fault_stage;
        logic [RUN_PAD_BITS-1:0]    pad;
    } srl_run_view_t;

    // Opcode occupies the top two bits in both views
    typedef union packed {
        srl_load_view_t load;
        srl_run_view_t  run;
    } srl_cmd_u;

endpackage

// File: hdl/srl_test_params.svh
`ifndef SRL_TEST_PARAMS_SVH
`define SRL_TEST_PARAMS_SVH

// Lane array geometry
`define SRL_NUM_LANES    8
`define SRL_LANE_BITS    3
`define SRL_LENGTH       32
`define SRL_TAP_BITS     5

// Test pattern loaded in 32-bit words
`define SRL_PATTERN_BITS 256
`define SRL_WORD_BITS    32

// Host command word width
`define SRL_CMD_BITS     40

// Per-lane error counter width
`define SRL_COUNT_BITS   16

`endif
